// File: list.f
+incdir+hw
+incdir+testbench
hw/rv_exec_pkg.sv
hw/int_alu.sv
hw/shift_unit.sv
hw/mul_div_unit.sv
hw/execute_stage.sv
testbench/execute_stage_tb.sv

// File: testbench/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

`include "rv_exec_config.svh"

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        lfsr_next = (state >> 1) ^ 32'h8020_0003;
    end else begin
        lfsr_next = state >> 1;
    end
endfunction

function automatic logic [63:0] sext32(input logic [31:0] w);
    sext32 = {{32{w[31]}}, w};
endfunction

function automatic logic word_divide(input logic [5:0] op);
    word_divide = (op == `OP_DIVW) || (op == `OP_DIVUW) || (op == `OP_REMW) ||
                  (op == `OP_REMUW);
endfunction

function automatic logic [63:0] model_divide(input logic [5:0] op, input logic [63:0] a,
                                             input logic [63:0] b);
    logic        is_signed;
    logic        want_rem;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] q;
    logic [63:0] r;
    is_signed = (op == `OP_DIV) || (op == `OP_REM) || (op == `OP_DIVW) || (op == `OP_REMW);
    want_rem  = (op == `OP_REM) || (op == `OP_REMU) || (op == `OP_REMW) || (op == `OP_REMUW);
    if (word_divide(op)) begin
        x = is_signed ? sext32(a[31:0]) : {32'd0, a[31:0]};
        y = is_signed ? sext32(b[31:0]) : {32'd0, b[31:0]};
    end else begin
        x = a;
        y = b;
    end
    if (y == 64'd0) begin
        q = '1;
        r = x;
    end else if (is_signed && (x == 64'h8000_0000_0000_0000) && (y == '1)) begin
        // quotient wraps back to the dividend
        q = x;
        r = '0;
    end else if (is_signed) begin
        q = $signed(x) / $signed(y);
        r = $signed(x) % $signed(y);
    end else begin
        q = x / y;
        r = x % y;
    end
    model_divide = want_rem ? r : q;
    if (word_divide(op)) begin
        model_divide = sext32(model_divide[31:0]);
    end
endfunction

function automatic logic [63:0] model_result(input logic [5:0] op, input logic [63:0] a,
                                             input logic [63:0] b, input logic [31:0] imm,
                                             input logic [63:0] pc);
    logic [63:0]  i;
    logic [127:0] p;
    i = sext32(imm);
    case (op)
        `OP_ADD:    model_result = a + b;
        `OP_ADDW:   model_result = sext32(a[31:0] + b[31:0]);
        `OP_SUB:    model_result = a - b;
        `OP_SUBW:   model_result = sext32(a[31:0] - b[31:0]);
        `OP_XOR:    model_result = a ^ b;
        `OP_OR:     model_result = a | b;
        `OP_AND:    model_result = a & b;
        `OP_ADDI:   model_result = a + i;
        `OP_ADDIW:  model_result = sext32(a[31:0] + imm);
        `OP_XORI:   model_result = a ^ i;
        `OP_ORI:    model_result = a | i;
        `OP_ANDI:   model_result = a & i;
        `OP_SLT:    model_result = {63'd0, $signed(a) < $signed(b)};
        `OP_SLTU:   model_result = {63'd0, a < b};
        `OP_SLTI:   model_result = {63'd0, $signed(a) < $signed(i)};
        `OP_SLTIU:  model_result = {63'd0, a < i};
        `OP_LUI:    model_result = i;
        `OP_AUIPC:  model_result = pc + i;
        `OP_JAL, `OP_JALR:   model_result = pc + 64'd4;
        `OP_LOAD, `OP_STORE: model_result = a + i;
        `OP_SLL:    model_result = a << b[5:0];
        `OP_SRL:    model_result = a >> b[5:0];
        `OP_SRA:    model_result = $signed(a) >>> b[5:0];
        `OP_SLLI:   model_result = a << imm[5:0];
        `OP_SRLI:   model_result = a >> imm[5:0];
        `OP_SRAI:   model_result = $signed(a) >>> imm[5:0];
        `OP_SLLW:   model_result = sext32(a[31:0] << b[4:0]);
        `OP_SRLW:   model_result = sext32(a[31:0] >> b[4:0]);
        `OP_SRAW:   model_result = sext32($signed(a[31:0]) >>> b[4:0]);
        `OP_SLLIW:  model_result = sext32(a[31:0] << imm[4:0]);
        `OP_SRLIW:  model_result = sext32(a[31:0] >> imm[4:0]);
        `OP_SRAIW:  model_result = sext32($signed(a[31:0]) >>> imm[4:0]);
        `OP_MUL:    model_result = a * b;
        `OP_MULW:   model_result = sext32(a[31:0] * b[31:0]);
        `OP_MULH: begin
            p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
            model_result = p[127:64];
        end
        `OP_MULHSU: begin
            p = {{64{a[63]}}, a} * {64'd0, b};
            model_result = p[127:64];
        end
        `OP_MULHU: begin
            p = {64'd0, a} * {64'd0, b};
            model_result = p[127:64];
        end
        `OP_DIV, `OP_DIVU, `OP_REM, `OP_REMU, `OP_DIVW, `OP_DIVUW, `OP_REMW, `OP_REMUW:
            model_result = model_divide(op, a, b);
        default: model_result = '0;
    endcase
endfunction

function automatic logic model_branch(input logic [5:0] op);
    model_branch = (op == `OP_JAL) || (op == `OP_JALR);
endfunction

function automatic logic [63:0] model_target(input logic [5:0] op, input logic [63:0] a,
                                             input logic [31:0] imm, input logic [63:0] pc);
    if (op == `OP_JAL) begin
        model_target = pc + sext32(imm);
    end else if (op == `OP_JALR) begin
        model_target = (a + sext32(imm)) & ~64'd1;
    end else begin
        model_target = '0;
    end
endfunction

function automatic logic model_mem_active(input logic [5:0] op);
    model_mem_active = (op == `OP_LOAD) || (op == `OP_STORE);
endfunction

function automatic logic model_load(input logic [5:0] op);
    model_load = (op == `OP_LOAD);
endfunction

// cycles from the accepting edge to the edge that raises result_valid
function automatic int model_latency(input logic [5:0] op, input logic [63:0] b);
    logic zero_divisor;
    zero_divisor = word_divide(op) ? (b[31:0] == 32'd0) : (b == 64'd0);
    if (op < `OP_DIV) begin
        model_latency = 1;
    end else if (zero_divisor) begin
        model_latency = 2;
    end else begin
        model_latency = `DIV_STEPS + 2;
    end
endfunction

`endif

// File: testbench/execute_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module execute_stage_tb;
    import rv_exec_pkg::*;

    `include "exec_ref_model.svh"

    localparam int MAX_ROWS      = 128;
    localparam int CLK_PERIOD    = 40;
    localparam int MODE_RANDOM   = 0;
    localparam int MODE_CORNER   = 1;
    localparam int MODE_ZERO_DIV = 2;
    localparam logic [63:0] MIN64 = 64'h8000_0000_0000_0000;
    localparam logic [63:0] ONES  = 64'hFFFF_FFFF_FFFF_FFFF;

    logic     clk;
    logic     reset;
    logic     in_valid;
    aluop_t   op;
    reg_idx_t rd;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    imm_t     imm;
    xlen_t    pc;
    logic     stall;
    logic     result_valid;
    xlen_t    result;
    reg_idx_t dest_reg;
    logic     branch;
    xlen_t    target_pc;
    logic     mem_active;
    logic     load;

    string    row_name     [MAX_ROWS];
    aluop_t   row_op       [MAX_ROWS];
    reg_idx_t row_rd       [MAX_ROWS];
    xlen_t    row_rs1      [MAX_ROWS];
    xlen_t    row_rs2      [MAX_ROWS];
    imm_t     row_imm      [MAX_ROWS];
    xlen_t    row_pc       [MAX_ROWS];
    xlen_t    exp_result   [MAX_ROWS];
    logic     exp_branch   [MAX_ROWS];
    xlen_t    exp_target   [MAX_ROWS];
    logic     exp_mem      [MAX_ROWS];
    logic     exp_load     [MAX_ROWS];
    int       exp_latency  [MAX_ROWS];
    int       accept_cycle [MAX_ROWS];
    int       pending[$];
    int       row_count     = 0;
    int       checked_count = 0;
    int       cycle         = 0;
    logic [31:0] lfsr_state = 32'd40;

    execute_stage UUT (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .op           (op),
        .rd           (rd),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .imm          (imm),
        .pc           (pc),
        .stall        (stall),
        .result_valid (result_valid),
        .result       (result),
        .dest_reg     (dest_reg),
        .branch       (branch),
        .target_pc    (target_pc),
        .mem_active   (mem_active),
        .load         (load)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic random_bits(input int count, output logic [63:0] value);
        int n;
        value = '0;
        for (n = 0; n < count; n++) begin
            value = {value[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input aluop_t o, input int mode,
                           input xlen_t a, input xlen_t b, input imm_t i);
        int          idx;
        logic [63:0] r;
        idx = row_count;
        row_name[idx] = name;
        row_op[idx]   = o;
        if (mode == MODE_CORNER) begin
            row_rs1[idx] = a;
            row_rs2[idx] = b;
            row_imm[idx] = i;
        end else begin
            random_bits(64, r);
            row_rs1[idx] = r;
            random_bits(64, r);
            row_rs2[idx] = r;
            random_bits(32, r);
            row_imm[idx] = r[31:0];
        end
        if (mode == MODE_ZERO_DIV) begin
            // word forms keep random upper bits that must be ignored
            row_rs2[idx] = word_divide(o) ? {row_rs2[idx][63:32], 32'd0} : 64'd0;
        end
        random_bits(5, r);
        row_rd[idx] = r[4:0];
        random_bits(62, r);
        row_pc[idx] = {r[61:0], 2'b00};
        exp_result[idx]  = model_result(o, row_rs1[idx], row_rs2[idx], row_imm[idx], row_pc[idx]);
        exp_branch[idx]  = model_branch(o);
        exp_target[idx]  = model_target(o, row_rs1[idx], row_imm[idx], row_pc[idx]);
        exp_mem[idx]     = model_mem_active(o);
        exp_load[idx]    = model_load(o);
        exp_latency[idx] = model_latency(o, row_rs2[idx]);
        row_count = row_count + 1;
    endtask

    task automatic build_table();
        int o;
        for (o = `OP_ADD; o <= `OP_STORE; o++) begin
            add_row($sformatf("op%0d random", o), o[5:0], MODE_RANDOM, 0, 0, 0);
        end
        add_row("sltu top bit", `OP_SLTU, MODE_CORNER, MIN64, 64'd1, 0);
        add_row("sltu all ones", `OP_SLTU, MODE_CORNER, 64'd1, ONES, 0);
        add_row("slt negative", `OP_SLT, MODE_CORNER, ONES, 64'd1, 0);
        add_row("sltiu negative imm", `OP_SLTIU, MODE_CORNER, 64'd5, 0, 32'hFFFF_F800);
        add_row("addw overflow", `OP_ADDW, MODE_CORNER, 64'h7FFF_FFFF, 64'd1, 0);
        add_row("jalr odd target", `OP_JALR, MODE_CORNER, 64'h1000_0003, 0, 32'h2);
        add_row("jal negative offset", `OP_JAL, MODE_CORNER, 0, 0, 32'hFFFF_FFF0);
        add_row("load negative offset", `OP_LOAD, MODE_CORNER, 64'h2000, 0, 32'hFFFF_FFF8);
        for (o = `OP_SLL; o <= `OP_SRAIW; o++) begin
            add_row($sformatf("op%0d random", o), o[5:0], MODE_RANDOM, 0, 0, 0);
        end
        add_row("sll by 0", `OP_SLL, MODE_CORNER, 64'hDEAD_BEEF_0123_4567, 64'd0, 0);
        add_row("sll by 63", `OP_SLL, MODE_CORNER, 64'd1, 64'd63, 0);
        add_row("srl by 63", `OP_SRL, MODE_CORNER, MIN64, 64'd63, 0);
        add_row("srl by 32", `OP_SRL, MODE_CORNER, 64'hF000_0000_1234_5678, 64'd32, 0);
        add_row("sra by 63 negative", `OP_SRA, MODE_CORNER, MIN64, 64'd63, 0);
        add_row("srai by 32 negative", `OP_SRAI, MODE_CORNER, 64'hF000_0000_1234_5678, 0, 32);
        add_row("sllw by 31", `OP_SLLW, MODE_CORNER, 64'd1, 64'd31, 0);
        add_row("srlw by 31", `OP_SRLW, MODE_CORNER, 64'h8000_0000, 64'd31, 0);
        add_row("sraw by 31 negative", `OP_SRAW, MODE_CORNER, 64'h1234_5678_8000_0000, 64'd31, 0);
        add_row("sraw amount 32", `OP_SRAW, MODE_CORNER, 64'h8000_0010, 64'd32, 0);
        add_row("slliw sign extension", `OP_SLLIW, MODE_CORNER, 64'h4000_0001, 0, 32'd1);
        for (o = `OP_MUL; o <= `OP_MULHU; o++) begin
            add_row($sformatf("op%0d random", o), o[5:0], MODE_RANDOM, 0, 0, 0);
        end
        add_row("mul most negative", `OP_MUL, MODE_CORNER, MIN64, ONES, 0);
        add_row("mulw most negative", `OP_MULW, MODE_CORNER, 64'h8000_0000, ONES, 0);
        add_row("mulh most negative", `OP_MULH, MODE_CORNER, MIN64, MIN64, 0);
        add_row("mulhsu most negative", `OP_MULHSU, MODE_CORNER, MIN64, ONES, 0);
        add_row("mulhu all ones", `OP_MULHU, MODE_CORNER, ONES, ONES, 0);
        for (o = `OP_DIV; o <= `OP_REMUW; o++) begin
            add_row($sformatf("op%0d random", o), o[5:0], MODE_RANDOM, 0, 0, 0);
            add_row($sformatf("op%0d zero divisor", o), o[5:0], MODE_ZERO_DIV, 0, 0, 0);
        end
        add_row("div overflow", `OP_DIV, MODE_CORNER, MIN64, ONES, 0);
        add_row("rem overflow", `OP_REM, MODE_CORNER, MIN64, ONES, 0);
        add_row("divw overflow", `OP_DIVW, MODE_CORNER, 64'h8000_0000, ONES, 0);
        add_row("remw overflow", `OP_REMW, MODE_CORNER, 64'h8000_0000, ONES, 0);
        add_row("div negative", `OP_DIV, MODE_CORNER, 64'hFFFF_FFFF_FFFF_FFF9, 64'd2, 0);
        add_row("rem negative", `OP_REM, MODE_CORNER, 64'hFFFF_FFFF_FFFF_FFF9, 64'd2, 0);
        add_row("divu top bit", `OP_DIVU, MODE_CORNER, ONES, 64'd3, 0);
    endtask

    // results are compared in acceptance order
    always @(negedge clk) begin : result_monitor
        int idx;
        if (!reset && result_valid) begin
            if (pending.size() == 0) begin
                $display("result_valid pulsed with no operation outstanding");
                $display("Simulation failed");
                $fatal(1, "unexpected result");
            end
            idx = pending.pop_front();
            check_value($sformatf("%s result", row_name[idx]), exp_result[idx], result);
            check_value($sformatf("%s dest_reg", row_name[idx]), row_rd[idx], dest_reg);
            check_value($sformatf("%s branch", row_name[idx]), exp_branch[idx], branch);
            if (exp_branch[idx]) begin
                check_value($sformatf("%s target", row_name[idx]), exp_target[idx], target_pc);
            end
            check_value($sformatf("%s mem_active", row_name[idx]), exp_mem[idx], mem_active);
            check_value($sformatf("%s load", row_name[idx]), exp_load[idx], load);
            check_value($sformatf("%s latency", row_name[idx]), exp_latency[idx],
                        cycle - accept_cycle[idx]);
            // a finished divide releases decode in the same cycle
            if (row_op[idx] >= `OP_DIV) begin
                check_value($sformatf("%s stall release", row_name[idx]), 0, stall);
            end
            checked_count = checked_count + 1;
        end
    end

    initial begin : stimulus
        int i;
        reset    = 1'b1;
        in_valid = 1'b0;
        op       = '0;
        rd       = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        imm      = '0;
        pc       = '0;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset result_valid", 0, result_valid);
        check_value("reset branch", 0, branch);
        check_value("reset mem_active", 0, mem_active);
        check_value("reset load", 0, load);
        check_value("reset stall", 0, stall);
        for (i = 0; i < row_count; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            op       <= row_op[i];
            rd       <= row_rd[i];
            rs1_val  <= row_rs1[i];
            rs2_val  <= row_rs2[i];
            imm      <= row_imm[i];
            pc       <= row_pc[i];
            // the row is taken at the next rising edge once stall is low
            @(negedge clk);
            while (stall) @(negedge clk);
            accept_cycle[i] = cycle + 1;
            pending.push_back(i);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (checked_count < row_count) @(negedge clk);
        // stage must be idle once the last result has left
        @(negedge clk);
        if (result_valid || stall) begin
            $display("the stage was still active after the last result");
            $display("Simulation failed");
            $fatal(1, "stage not idle");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    initial begin : watchdog
        #1;
        #((row_count * (`DIV_STEPS + 4) + 4) * CLK_PERIOD);
        $display("Timeout: results stopped arriving from the execute stage");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module execute_stage (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        in_valid,
    input  wire rv_exec_pkg::aluop_t   op,
    input  wire rv_exec_pkg::reg_idx_t rd,
    input  wire rv_exec_pkg::xlen_t    rs1_val,
    input  wire rv_exec_pkg::xlen_t    rs2_val,
    input  wire rv_exec_pkg::imm_t     imm,
    input  wire rv_exec_pkg::xlen_t    pc,
    output logic                       stall,
    output logic                       result_valid,
    output rv_exec_pkg::xlen_t         result,
    output rv_exec_pkg::reg_idx_t      dest_reg,
    output logic                       branch,
    output rv_exec_pkg::xlen_t         target_pc,
    output logic                       mem_active,
    output logic                       load
);
    import rv_exec_pkg::*;

    aluop_t   op_q;
    reg_idx_t rd_q;
    xlen_t    rs1_q;
    xlen_t    rs2_q;
    imm_t     imm_q;
    xlen_t    pc_q;
    logic     occ_q;
    logic     fresh_q;
    logic     accept;
    logic     op_done;
    logic     is_shift;
    logic     is_mul;
    logic     is_div;
    logic     div_start;
    logic     div_done;
    xlen_t    alu_result;
    logic     alu_branch;
    xlen_t    alu_target;
    logic     alu_mem_active;
    logic     alu_load;
    xlen_t    shift_result;
    xlen_t    mul_result;
    xlen_t    div_result;
    xlen_t    unit_result;

    assign is_shift  = `IS_SHIFT_OP(op_q);
    assign is_mul    = `IS_MUL_OP(op_q);
    assign is_div    = `IS_DIV_OP(op_q);
    // a divide holds the operand register until its result is taken
    assign stall     = occ_q & is_div;
    assign accept    = in_valid & ~stall;
    assign div_start = fresh_q & is_div;
    assign op_done   = occ_q & (~is_div | div_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            occ_q   <= 1'b0;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= accept;
            if (accept) begin
                occ_q <= 1'b1;
            end else if (op_done) begin
                occ_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= op;
            rd_q  <= rd;
            rs1_q <= rs1_val;
            rs2_q <= rs2_val;
            imm_q <= imm;
            pc_q  <= pc;
        end
    end

    int_alu u_int_alu (
        .op         (op_q),
        .rs1_val    (rs1_q),
        .rs2_val    (rs2_q),
        .imm        (imm_q),
        .pc         (pc_q),
        .result     (alu_result),
        .branch     (alu_branch),
        .target_pc  (alu_target),
        .mem_active (alu_mem_active),
        .load       (alu_load)
    );

    shift_unit u_shift_unit (
        .op      (op_q),
        .rs1_val (rs1_q),
        .rs2_val (rs2_q),
        .imm     (imm_q),
        .result  (shift_result)
    );

    mul_div_unit u_mul_div_unit (
        .clk        (clk),
        .reset      (reset),
        .op         (op_q),
        .rs1_val    (rs1_q),
        .rs2_val    (rs2_q),
        .div_start  (div_start),
        .mul_result (mul_result),
        .div_result (div_result),
        .div_done   (div_done)
    );

    always_comb begin
        if (is_div) begin
            unit_result = div_result;
        end else if (is_mul) begin
            unit_result = mul_result;
        end else if (is_shift) begin
            unit_result = shift_result;
        end else begin
            unit_result = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            branch       <= 1'b0;
            mem_active   <= 1'b0;
            load         <= 1'b0;
        end else begin
            result_valid <= op_done;
            branch       <= op_done & alu_branch;
            mem_active   <= op_done & alu_mem_active;
            load         <= op_done & alu_load;
        end
    end

    always_ff @(posedge clk) begin
        if (op_done) begin
            result    <= unit_result;
            dest_reg  <= rd_q;
            target_pc <= alu_target;
        end
    end

    // past the divide's first cycle nothing else may complete
    a_no_result_in_divide: assert property (@(posedge clk) disable iff (reset)
        stall && !div_start |-> !result_valid);

    a_dest_held_in_divide: assert property (@(posedge clk) disable iff (reset)
        stall && !div_start |-> $stable(dest_reg));

endmodule

`default_nettype wire

// File: hw/mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module mul_div_unit (
    input  wire                      clk,
    input  wire                      reset,
    input  wire rv_exec_pkg::aluop_t op,
    input  wire rv_exec_pkg::xlen_t  rs1_val,
    input  wire rv_exec_pkg::xlen_t  rs2_val,
    input  wire                      div_start,
    output rv_exec_pkg::xlen_t       mul_result,
    output rv_exec_pkg::xlen_t       div_result,
    output logic                     div_done
);
    import rv_exec_pkg::*;

    logic                a_signed;
    logic                b_signed;
    logic signed [64:0]  mul_a;
    logic signed [64:0]  mul_b;
    logic signed [129:0] product;

    div_state_t                    state;
    logic                          op_signed;
    logic                          op_word;
    xlen_t                         dvd_ext;
    xlen_t                         dvs_ext;
    logic                          dvd_neg;
    logic                          dvs_neg;
    logic                          dvs_zero;
    xlen_t                         quo_acc;
    xlen_t                         rem_acc;
    xlen_t                         divisor_mag;
    logic [$clog2(`DIV_STEPS)-1:0] step_cnt;
    logic [`XLEN:0]                trial;
    logic                          neg_quot;
    logic                          neg_rem;
    logic                          want_rem;
    logic                          word_op;
    xlen_t                         quo_fix;
    xlen_t                         rem_fix;
    xlen_t                         sel_fix;

    // one 65x65 signed multiply covers all three sign mixes
    assign a_signed = op inside {`OP_MULH, `OP_MULHSU};
    assign b_signed = (op == `OP_MULH);
    assign mul_a    = {a_signed & rs1_val[`XLEN-1], rs1_val};
    assign mul_b    = {b_signed & rs2_val[`XLEN-1], rs2_val};
    assign product  = mul_a * mul_b;

    always_comb begin
        case (op)
            `OP_MULW: mul_result = {{32{product[31]}}, product[31:0]};
            `OP_MULH, `OP_MULHSU, `OP_MULHU: mul_result = product[127:64];
            default: mul_result = product[63:0];
        endcase
    end

    assign op_signed = op inside {`OP_DIV, `OP_REM, `OP_DIVW, `OP_REMW};
    assign op_word   = op inside {`OP_DIVW, `OP_DIVUW, `OP_REMW, `OP_REMUW};

    always_comb begin
        if (op_word && op_signed) begin
            dvd_ext = {{32{rs1_val[31]}}, rs1_val[31:0]};
            dvs_ext = {{32{rs2_val[31]}}, rs2_val[31:0]};
        end else if (op_word) begin
            dvd_ext = {32'd0, rs1_val[31:0]};
            dvs_ext = {32'd0, rs2_val[31:0]};
        end else begin
            dvd_ext = rs1_val;
            dvs_ext = rs2_val;
        end
    end

    assign dvd_neg  = op_signed & dvd_ext[`XLEN-1];
    assign dvs_neg  = op_signed & dvs_ext[`XLEN-1];
    assign dvs_zero = (dvs_ext == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: if (div_start) state <= dvs_zero ? DIV_DONE : DIV_RUN;
                DIV_RUN:  if (step_cnt == `DIV_STEPS - 1) state <= DIV_DONE;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    // restoring step, shift in the next dividend bit and try a subtract
    assign trial = {rem_acc, quo_acc[`XLEN-1]} - {1'b0, divisor_mag};

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && div_start) begin
            want_rem    <= op inside {`OP_REM, `OP_REMU, `OP_REMW, `OP_REMUW};
            word_op     <= op_word;
            step_cnt    <= '0;
            divisor_mag <= dvs_neg ? -dvs_ext : dvs_ext;
            if (dvs_zero) begin
                quo_acc  <= '1;
                rem_acc  <= dvd_ext;
                neg_quot <= 1'b0;
                neg_rem  <= 1'b0;
            end else begin
                quo_acc  <= dvd_neg ? -dvd_ext : dvd_ext;
                rem_acc  <= '0;
                neg_quot <= dvd_neg ^ dvs_neg;
                neg_rem  <= dvd_neg;
            end
        end else if (state == DIV_RUN) begin
            step_cnt <= step_cnt + 1'b1;
            quo_acc  <= {quo_acc[`XLEN-2:0], ~trial[`XLEN]};
            if (trial[`XLEN]) begin
                rem_acc <= {rem_acc[`XLEN-2:0], quo_acc[`XLEN-1]};
            end else begin
                rem_acc <= trial[`XLEN-1:0];
            end
        end
    end

    // remainder takes the dividend's sign
    assign quo_fix    = neg_quot ? -quo_acc : quo_acc;
    assign rem_fix    = neg_rem ? -rem_acc : rem_acc;
    assign sel_fix    = want_rem ? rem_fix : quo_fix;
    assign div_result = word_op ? {{32{sel_fix[31]}}, sel_fix[31:0]} : sel_fix;
    assign div_done   = (state == DIV_DONE);

    a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
        div_start |-> state == DIV_IDLE);

    a_done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        div_done |=> !div_done);

endmodule

`default_nettype wire

// File: hw/shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module shift_unit (
    input  wire rv_exec_pkg::aluop_t op,
    input  wire rv_exec_pkg::xlen_t  rs1_val,
    input  wire rv_exec_pkg::xlen_t  rs2_val,
    input  wire rv_exec_pkg::imm_t   imm,
    output rv_exec_pkg::xlen_t       result
);
    import rv_exec_pkg::*;

    logic       use_imm;
    logic       word_form;
    logic [5:0] shamt;
    word_t      word_in;
    word_t      word_res;
    xlen_t      dword_res;

    assign use_imm   = op inside {`OP_SLLI, `OP_SRLI, `OP_SRAI,
                                  `OP_SLLIW, `OP_SRLIW, `OP_SRAIW};
    assign word_form = op inside {`OP_SLLW, `OP_SRLW, `OP_SRAW,
                                  `OP_SLLIW, `OP_SRLIW, `OP_SRAIW};
    assign shamt     = use_imm ? imm[5:0] : rs2_val[5:0];
    assign word_in   = rs1_val[31:0];

    always_comb begin
        word_res  = '0;
        dword_res = '0;
        case (op)
            `OP_SLL, `OP_SLLI:   dword_res = rs1_val << shamt;
            `OP_SRL, `OP_SRLI:   dword_res = rs1_val >> shamt;
            `OP_SRA, `OP_SRAI:   dword_res = $signed(rs1_val) >>> shamt;
            // word forms only look at five bits of the amount
            `OP_SLLW, `OP_SLLIW: word_res = word_in << shamt[4:0];
            `OP_SRLW, `OP_SRLIW: word_res = word_in >> shamt[4:0];
            `OP_SRAW, `OP_SRAIW: word_res = $signed(word_in) >>> shamt[4:0];
            default: begin
                dword_res = '0;
            end
        endcase
    end

    assign result = word_form ? {{32{word_res[31]}}, word_res} : dword_res;

endmodule

`default_nettype wire

// File: hw/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module int_alu (
    input  wire rv_exec_pkg::aluop_t op,
    input  wire rv_exec_pkg::xlen_t  rs1_val,
    input  wire rv_exec_pkg::xlen_t  rs2_val,
    input  wire rv_exec_pkg::imm_t   imm,
    input  wire rv_exec_pkg::xlen_t  pc,
    output rv_exec_pkg::xlen_t       result,
    output logic                     branch,
    output rv_exec_pkg::xlen_t       target_pc,
    output logic                     mem_active,
    output logic                     load
);
    import rv_exec_pkg::*;

    xlen_t imm_ext;
    xlen_t addr_sum;
    xlen_t pc_imm;
    word_t word_sum;
    word_t word_diff;

    assign imm_ext   = {{32{imm[31]}}, imm};
    // shared by addi, jalr and the memory ops
    assign addr_sum  = rs1_val + imm_ext;
    assign pc_imm    = pc + imm_ext;
    assign word_sum  = rs1_val[31:0] + rs2_val[31:0];
    assign word_diff = rs1_val[31:0] - rs2_val[31:0];

    always_comb begin
        result     = '0;
        branch     = 1'b0;
        target_pc  = '0;
        mem_active = 1'b0;
        load       = 1'b0;
        case (op)
            `OP_ADD:   result = rs1_val + rs2_val;
            `OP_ADDW:  result = {{32{word_sum[31]}}, word_sum};
            `OP_SUB:   result = rs1_val - rs2_val;
            `OP_SUBW:  result = {{32{word_diff[31]}}, word_diff};
            `OP_XOR:   result = rs1_val ^ rs2_val;
            `OP_OR:    result = rs1_val | rs2_val;
            `OP_AND:   result = rs1_val & rs2_val;
            `OP_ADDI:  result = addr_sum;
            `OP_ADDIW: result = {{32{addr_sum[31]}}, addr_sum[31:0]};
            `OP_XORI:  result = rs1_val ^ imm_ext;
            `OP_ORI:   result = rs1_val | imm_ext;
            `OP_ANDI:  result = rs1_val & imm_ext;
            `OP_SLT:   result = xlen_t'($signed(rs1_val) < $signed(rs2_val));
            `OP_SLTU:  result = xlen_t'(rs1_val < rs2_val);
            `OP_SLTI:  result = xlen_t'($signed(rs1_val) < $signed(imm_ext));
            // immediate is sign extended first, then compared unsigned
            `OP_SLTIU: result = xlen_t'(rs1_val < imm_ext);
            `OP_LUI:   result = imm_ext;
            `OP_AUIPC: result = pc_imm;
            `OP_JAL: begin
                result    = pc + 64'd4;
                branch    = 1'b1;
                target_pc = pc_imm;
            end
            `OP_JALR: begin
                result    = pc + 64'd4;
                branch    = 1'b1;
                target_pc = {addr_sum[`XLEN-1:1], 1'b0};
            end
            `OP_LOAD: begin
                result     = addr_sum;
                mem_active = 1'b1;
                load       = 1'b1;
            end
            `OP_STORE: begin
                result     = addr_sum;
                mem_active = 1'b1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [31:0]      word_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [31:0]      imm_t;
    typedef logic [5:0]       aluop_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

// File: hw/rv_exec_config.svh
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

`define XLEN      64
`define DIV_STEPS 64

// integer and logic, 0x00 - 0x0b
`define OP_ADD    6'd0
`define OP_ADDW   6'd1
`define OP_SUB    6'd2
`define OP_SUBW   6'd3
`define OP_XOR    6'd4
`define OP_OR     6'd5
`define OP_AND    6'd6
`define OP_ADDI   6'd7
`define OP_ADDIW  6'd8
`define OP_XORI   6'd9
`define OP_ORI    6'd10
`define OP_ANDI   6'd11

// compares
`define OP_SLT    6'd12
`define OP_SLTU   6'd13
`define OP_SLTI   6'd14
`define OP_SLTIU  6'd15

// upper immediate, jumps, memory
`define OP_LUI    6'd16
`define OP_AUIPC  6'd17
`define OP_JAL    6'd18
`define OP_JALR   6'd19
`define OP_LOAD   6'd20
`define OP_STORE  6'd21

// shifts occupy 0x20 - 0x2b
`define OP_SLL    6'd32
`define OP_SRL    6'd33
`define OP_SRA    6'd34
`define OP_SLLI   6'd35
`define OP_SRLI   6'd36
`define OP_SRAI   6'd37
`define OP_SLLW   6'd38
`define OP_SRLW   6'd39
`define OP_SRAW   6'd40
`define OP_SLLIW  6'd41
`define OP_SRLIW  6'd42
`define OP_SRAIW  6'd43

// multiplies occupy 0x30 - 0x34
`define OP_MUL    6'd48
`define OP_MULW   6'd49
`define OP_MULH   6'd50
`define OP_MULHSU 6'd51
`define OP_MULHU  6'd52

// divides occupy 0x38 - 0x3f
`define OP_DIV    6'd56
`define OP_DIVU   6'd57
`define OP_REM    6'd58
`define OP_REMU   6'd59
`define OP_DIVW   6'd60
`define OP_DIVUW  6'd61
`define OP_REMW   6'd62
`define OP_REMUW  6'd63

`define IS_SHIFT_OP(o) (((o) >= `OP_SLL) && ((o) <= `OP_SRAIW))
`define IS_MUL_OP(o)   (((o) >= `OP_MUL) && ((o) <= `OP_MULHU))
`define IS_DIV_OP(o)   ((o) >= `OP_DIV)

`endif
